//--- design/mspe_pkg.sv
package mspe_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int CORES           = 4;
    localparam int CORE_SEL_W      = 2;
    localparam int INSN_DEPTH      = 6;  // log2 words per core
    localparam int FIFO_DEPTH_LOG2 = 3;
    localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;
    localparam int CNT_W           = FIFO_DEPTH_LOG2 + 1;
    localparam int WORD_W          = 32;
    localparam int LANES           = 16;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////
    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [LANES-1:0] beat_t;  // Lane 15 in the top bits

    typedef enum logic [3:0] {
        NOP    = 4'h0,
        LOADB,
        ADDI,
        XORI,
        STOREB,
        STOREE,
        PUTC,
        JMP,
        HALT
    } opcode_t;

    typedef struct packed {
        beat_t data;
        logic  eop;
    } src_entry_t;

    ////////////////////////////////////////
    // CSR map
    ////////////////////////////////////////
    localparam word_t VERSION = 32'h3434_0002;

    localparam logic [4:0] CSR_RUN_W     = 5'd0;
    localparam logic [4:0] CSR_VERSION_R = 5'd0;
    localparam logic [4:0] CSR_RUN_R     = 5'd1;
    localparam logic [4:0] CSR_STATUS_R  = 5'd2;
    localparam logic [4:0] CSR_KICK      = 5'd13;  // Bit 0 write, bit 1 read
    localparam logic [4:0] CSR_ADDR_HI   = 5'd14;
    localparam logic [4:0] CSR_ADDR_LO   = 5'd15;
    localparam logic [4:0] CSR_DATA_BASE = 5'd16;

endpackage

//--- design/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo import mspe_pkg::*; #(
    parameter type payload_t = beat_t
) (
    input  logic             clk,
    input  logic             reset,
    input  payload_t         din,
    input  logic             we,
    input  logic             re,
    output payload_t         q,
    output logic [CNT_W-1:0] count,
    output logic             empty,
    output logic             full
);

    payload_t                   mem [FIFO_DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;

    assign q     = mem[rd_ptr];  // Show-ahead head
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (re) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({we, re})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) we |-> !full)
        else $error("stream_fifo: write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset) re |-> !empty)
        else $error("stream_fifo: read while empty");

endmodule

//--- design/mspe_csr.sv
`timescale 1ns/100ps

module mspe_csr import mspe_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       csr_address,
    input  word_t            csr_writedata,
    input  logic             csr_write,
    input  logic             csr_read,
    input  logic [3:0]       csr_byteenable,
    output word_t            csr_readdata,
    output logic [CORES-1:0] core_run,
    input  logic [CORES-1:0] core_halted,
    input  logic             m0_waitrequest,
    input  beat_t            m0_readdata,
    input  logic             m0_readdatavalid,
    output logic [63:0]      m0_address,
    output beat_t            m0_writedata,
    output logic             m0_write,
    output logic             m0_read
);

    word_t      run_mask;
    beat_t      rdata_cap;
    logic [1:0] kick;        // {read, write}
    logic [1:0] kick_d;
    logic       write_edge;
    logic       read_edge;
    logic [3:0] win_lane;

    assign core_run   = run_mask[CORES-1:0];
    assign write_edge = kick[0] && !kick_d[0];
    assign read_edge  = kick[1] && !kick_d[1];
    assign win_lane   = ~csr_address[3:0];  // Address 16 is lane 15

    ////////////////////////////////////////
    // Run mask and master strobes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            run_mask <= '0;
            kick     <= '0;
            kick_d   <= '0;
            m0_write <= 1'b0;
            m0_read  <= 1'b0;
        end else begin
            kick_d <= kick;

            // A kick is dropped while the other strobe is busy
            if (write_edge && !m0_read) begin
                m0_write <= 1'b1;
            end else if (!m0_waitrequest) begin
                m0_write <= 1'b0;
            end
            if (read_edge && !write_edge && !m0_write) begin
                m0_read <= 1'b1;
            end else if (!m0_waitrequest) begin
                m0_read <= 1'b0;
            end

            if (csr_write && csr_address == CSR_RUN_W) begin
                for (int b = 0; b < 4; b++) begin
                    if (csr_byteenable[b]) begin
                        run_mask[8*b +: 8] <= csr_writedata[8*b +: 8];
                    end
                end
            end
            if (csr_write && csr_address == CSR_KICK) begin
                kick <= csr_writedata[1:0];
            end
        end
    end

    ////////////////////////////////////////
    // Address and data windows
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (csr_write) begin
            if (csr_address == CSR_ADDR_HI) begin
                m0_address[63:32] <= csr_writedata;
            end
            if (csr_address == CSR_ADDR_LO) begin
                m0_address[31:0] <= csr_writedata;
            end
            if (csr_address >= CSR_DATA_BASE) begin
                m0_writedata[win_lane] <= csr_writedata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_cap <= '1;
        end else if (m0_readdatavalid) begin
            rdata_cap <= m0_readdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_readdata <= '0;
        end else if (csr_read) begin
            if (csr_address >= CSR_DATA_BASE) begin
                csr_readdata <= rdata_cap[win_lane];
            end else begin
                case (csr_address)
                    CSR_VERSION_R: csr_readdata <= VERSION;
                    CSR_RUN_R:     csr_readdata <= run_mask;
                    CSR_STATUS_R:  csr_readdata <= word_t'(core_halted);
                    default:       csr_readdata <= 32'hDEAD_BEEF;
                endcase
            end
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(m0_write && m0_read))
        else $error("mspe_csr: m0_write and m0_read both high");

endmodule

//--- design/pe_core.sv
`timescale 1ns/100ps

module pe_core import mspe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    input  logic [INSN_DEPTH-1:0] insn_addr,
    input  word_t                 insn_din,
    input  logic                  insn_we,
    input  beat_t                 sink_q,
    input  logic                  sink_empty,
    output logic                  sink_re,
    output src_entry_t            src_din,
    output logic                  src_we,
    input  logic                  src_full,
    output word_t                 uart_dout,
    output logic                  uart_we,
    output logic                  halted
);

    word_t                 imem [2**INSN_DEPTH];
    logic [INSN_DEPTH-1:0] pc;
    word_t                 insn;
    opcode_t               op;
    word_t                 imm;
    beat_t                 acc;
    logic                  stall;
    logic                  step;

    assign insn = imem[pc];
    assign op   = opcode_t'(insn[31:28]);
    assign imm  = {16'h0000, insn[15:0]};

    always_comb begin
        case (op)
            LOADB:          stall = sink_empty;
            STOREB, STOREE: stall = src_full;
            default:        stall = 1'b0;
        endcase
    end

    assign step = run && !halted && !stall;  // One instruction retires

    assign sink_re      = step && (op == LOADB);
    assign src_we       = step && (op == STOREB || op == STOREE);
    assign src_din.data = acc;
    assign src_din.eop  = (op == STOREE);
    assign uart_we      = step && (op == PUTC);
    assign uart_dout    = imm;

    always_ff @(posedge clk) begin
        if (insn_we) begin
            imem[insn_addr] <= insn_din;
        end
    end

    ////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pc     <= '0;  // Stopped core parks at 0
            halted <= 1'b0;
        end else if (step) begin
            case (op)
                JMP:     pc <= imm[INSN_DEPTH-1:0];
                HALT:    halted <= 1'b1;
                default: pc <= pc + 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////
    // Beat register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (step) begin
            case (op)
                LOADB: begin
                    acc <= sink_q;
                end
                ADDI: begin
                    for (int l = 0; l < LANES; l++) begin
                        acc[l] <= acc[l] + imm;
                    end
                end
                XORI: begin
                    for (int l = 0; l < LANES; l++) begin
                        acc[l] <= acc[l] ^ imm;
                    end
                end
                default: begin
                    acc <= acc;
                end
            endcase
        end
    end

endmodule

//--- design/src_scheduler.sv
`timescale 1ns/100ps

module src_scheduler import mspe_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  src_entry_t       fifo_q [CORES],
    input  logic [CORES-1:0] fifo_empty,
    output logic [CORES-1:0] fifo_re,
    input  logic [CORES-1:0] eop_push,
    output beat_t            src_data,
    output logic             src_valid,
    output logic             src_sop,
    output logic             src_eop,
    input  logic             src_ready
);

    logic [CNT_W-1:0]      eop_cnt [CORES];  // Complete packets held
    logic [CORES-1:0]      eop_ready;
    logic                  busy;
    logic                  first;
    logic [CORE_SEL_W-1:0] cur;
    logic [CORE_SEL_W-1:0] pick;
    logic [CORE_SEL_W-1:0] idx;
    logic                  found;
    logic                  load;
    src_entry_t            head;

    assign head = fifo_q[cur];
    assign load = busy && !fifo_empty[cur] && (!src_valid || src_ready);

    always_comb begin
        fifo_re      = '0;
        fifo_re[cur] = load;
    end

    ////////////////////////////////////////
    // Round-robin scan from cur + 1
    ////////////////////////////////////////
    always_comb begin
        found = 1'b0;
        pick  = cur;
        idx   = cur;
        for (int i = 0; i < CORES; i++) begin
            eop_ready[i] = (eop_cnt[i] != '0);
        end
        for (int n = 1; n <= CORES; n++) begin
            idx = cur + CORE_SEL_W'(n);
            if (!found && eop_ready[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < CORES; i++) begin
            if (reset) begin
                eop_cnt[i] <= '0;
            end else begin
                eop_cnt[i] <= eop_cnt[i] + CNT_W'(eop_push[i])
                              - CNT_W'(fifo_re[i] && fifo_q[i].eop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            first     <= 1'b0;
            cur       <= CORE_SEL_W'(CORES - 1);  // Core 0 scanned first
            src_valid <= 1'b0;
        end else begin
            if (!busy && found) begin
                busy  <= 1'b1;
                first <= 1'b1;
                cur   <= pick;
            end else if (load) begin
                first <= 1'b0;
                if (head.eop) begin
                    busy <= 1'b0;
                end
            end
            if (load) begin
                src_valid <= 1'b1;
            end else if (src_ready) begin
                src_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            src_data <= head.data;
            src_sop  <= first;
            src_eop  <= head.eop;
        end
    end

    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        src_valid && !src_ready |=> src_valid && $stable(src_data))
        else $error("src_scheduler: output changed while stalled");

endmodule

//--- design/mspe.sv
`timescale 1ns/100ps

module mspe import mspe_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [4:0]                       csr_address,
    input  word_t                            csr_writedata,
    input  logic                             csr_write,
    output word_t                            csr_readdata,
    input  logic                             csr_read,
    input  logic [3:0]                       csr_byteenable,
    input  logic [CORE_SEL_W+INSN_DEPTH+1:0] insn_addr,
    input  word_t                            insn_din,
    input  logic                             insn_we,
    output word_t                            uart_dout,
    output logic                             uart_we,
    input  beat_t                            snk_data,
    input  logic                             snk_valid,
    input  logic                             snk_sop,
    input  logic                             snk_eop,
    output logic                             snk_ready,
    output beat_t                            src_data,
    output logic                             src_valid,
    output logic                             src_sop,
    output logic                             src_eop,
    input  logic                             src_ready,
    input  logic                             m0_waitrequest,
    input  beat_t                            m0_readdata,
    input  logic                             m0_readdatavalid,
    output logic [2:0]                       m0_burstcount,
    output beat_t                            m0_writedata,
    output logic [63:0]                      m0_address,
    output logic                             m0_write,
    output logic                             m0_read,
    output logic [63:0]                      m0_byteenable,
    output logic                             m0_debugaccess
);

    logic [CORES-1:0] core_run;
    logic [CORES-1:0] core_halted;
    logic [CORES-1:0] core_insn_we;
    logic [CORES-1:0] core_uart_we;
    word_t            core_uart_dout [CORES];
    logic [CORES-1:0] sink_re;
    logic [CORES-1:0] sink_empty;
    logic [CORES-1:0] sink_full;
    beat_t            sink_q [CORES];
    logic [CORES-1:0] src_we;
    logic [CORES-1:0] src_full;
    logic [CORES-1:0] src_re;
    logic [CORES-1:0] src_empty;
    logic [CORES-1:0] eop_push;
    src_entry_t       src_din [CORES];
    src_entry_t       src_q [CORES];
    logic             snk_push;

    assign m0_burstcount  = 3'd1;
    assign m0_byteenable  = '1;
    assign m0_debugaccess = 1'b0;

    assign snk_ready = ~|sink_full;
    assign snk_push  = snk_valid && snk_ready;  // Broadcast to every core

    always_comb begin
        uart_we   = 1'b0;
        uart_dout = '0;
        for (int i = 0; i < CORES; i++) begin
            if (core_uart_we[i]) begin  // Highest index wins
                uart_we   = 1'b1;
                uart_dout = core_uart_dout[i];
            end
        end
    end

    mspe_csr u_csr (
        .clk, .reset,
        .csr_address, .csr_writedata, .csr_write, .csr_read, .csr_byteenable, .csr_readdata,
        .core_run, .core_halted,
        .m0_waitrequest, .m0_readdata, .m0_readdatavalid,
        .m0_address, .m0_writedata, .m0_write, .m0_read
    );

    for (genvar i = 0; i < CORES; i++) begin : g_core
        assign core_insn_we[i] = insn_we &&
            (insn_addr[CORE_SEL_W+INSN_DEPTH+1:INSN_DEPTH+2] == CORE_SEL_W'(i));
        assign eop_push[i] = src_we[i] && src_din[i].eop;

        stream_fifo #(.payload_t(beat_t)) u_sink_fifo (
            .clk, .reset, .din(snk_data), .we(snk_push), .re(sink_re[i]),
            .q(sink_q[i]), .count(), .empty(sink_empty[i]), .full(sink_full[i])
        );

        pe_core u_core (
            .clk, .reset, .run(core_run[i]),
            .insn_addr(insn_addr[INSN_DEPTH+1:2]), .insn_din, .insn_we(core_insn_we[i]),
            .sink_q(sink_q[i]), .sink_empty(sink_empty[i]), .sink_re(sink_re[i]),
            .src_din(src_din[i]), .src_we(src_we[i]), .src_full(src_full[i]),
            .uart_dout(core_uart_dout[i]), .uart_we(core_uart_we[i]),
            .halted(core_halted[i])
        );

        stream_fifo #(.payload_t(src_entry_t)) u_src_fifo (
            .clk, .reset, .din(src_din[i]), .we(src_we[i]), .re(src_re[i]),
            .q(src_q[i]), .count(), .empty(src_empty[i]), .full(src_full[i])
        );
    end

    src_scheduler u_sched (
        .clk, .reset,
        .fifo_q(src_q), .fifo_empty(src_empty), .fifo_re(src_re), .eop_push,
        .src_data, .src_valid, .src_sop, .src_eop, .src_ready
    );

endmodule

//--- tb/mspe_checker.sv
`timescale 1ns/100ps

module mspe_checker import mspe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  beat_t       src_data,
    input  logic        src_valid,
    input  logic        src_sop,
    input  logic        src_eop,
    input  logic        src_ready,
    input  word_t       uart_dout,
    input  logic        uart_we,
    input  logic        m0_write,
    input  logic        m0_read,
    input  logic [63:0] m0_address,
    input  beat_t       m0_writedata,
    input  logic [63:0] m0_byteenable,
    input  logic [2:0]  m0_burstcount,
    input  logic        m0_debugaccess,
    output logic        m0_waitrequest,
    output beat_t       m0_readdata,
    output logic        m0_readdatavalid
);

    typedef struct packed {
        beat_t data;
        logic  sop;
        logic  eop;
    } out_t;

    int          errors = 0;
    int          checks = 0;
    int          writes_seen = 0;
    int          reads_seen = 0;
    logic [63:0] last_waddr;
    beat_t       last_wdata;
    logic [63:0] last_be;
    out_t        exp_q [$];
    word_t       uart_q [$];
    out_t        e;
    bit [31:0]   rand_state = 32'd53472;
    logic        hold_w = 1'b0;
    logic        hold_r = 1'b0;
    logic        stalled = 1'b0;
    out_t        stall_beat;
    logic        rd_pend = 1'b0;
    logic [63:0] rd_addr;

    initial begin
        m0_waitrequest   = 1'b0;
        m0_readdata      = '0;
        m0_readdatavalid = 1'b0;
    end

    function automatic logic next_bit();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[20];
    endfunction

    // Slave read data, every lane tied to the full address
    function automatic beat_t read_pattern(logic [63:0] addr);
        beat_t b;
        for (int l = 0; l < LANES; l++) begin
            b[l] = addr[63:32] ^ addr[31:0] ^ (32'h0101_0101 * (l + 1));
        end
        return b;
    endfunction

    task automatic check_val(string name, logic [511:0] exp, logic [511:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("FAILED %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_error(string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endtask

    task automatic expect_beat(beat_t data, logic sop, logic eop);
        exp_q.push_back({data, sop, eop});
    endtask

    task automatic expect_char(word_t c);
        uart_q.push_back(c);
    endtask

    function automatic int pending();
        return exp_q.size() + uart_q.size();
    endfunction

    task automatic check_drained();
        if (exp_q.size() != 0) report_error("expected output beats never appeared");
        if (uart_q.size() != 0) report_error("expected UART characters never appeared");
        exp_q.delete();
        uart_q.delete();
    endtask

    ////////////////////////////////////////
    // Memory slave and monitors
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!reset) begin
            if (hold_w && !m0_write) report_error("m0_write dropped during waitrequest");
            if (hold_r && !m0_read) report_error("m0_read dropped during waitrequest");
            hold_w = m0_write && m0_waitrequest;
            hold_r = m0_read && m0_waitrequest;
            if (m0_write && !m0_waitrequest) begin
                writes_seen++;
                last_waddr = m0_address;
                last_wdata = m0_writedata;
                last_be    = m0_byteenable;
                check_val("m0_burstcount", 1, m0_burstcount);
            end
            if ((m0_write || m0_read) && !m0_waitrequest) begin
                check_val("m0_debugaccess", 0, m0_debugaccess);
            end
            rd_pend = m0_read && !m0_waitrequest;
            rd_addr = m0_address;

            if (stalled && !(src_valid && {src_data, src_sop, src_eop} == stall_beat)) begin
                report_error("src output changed while stalled");
            end
            stalled    = src_valid && !src_ready;
            stall_beat = {src_data, src_sop, src_eop};
            if (src_valid && src_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("unexpected output beat");
                end else begin
                    e = exp_q.pop_front();
                    check_val("src_data", e.data, src_data);
                    check_val("src_sop", e.sop, src_sop);
                    check_val("src_eop", e.eop, src_eop);
                end
            end
            if (uart_we) begin
                if (uart_q.size() == 0) report_error("unexpected uart_we pulse");
                else check_val("uart_dout", uart_q.pop_front(), uart_dout);
            end
        end
        #2;
        m0_waitrequest   = next_bit();
        m0_readdatavalid = rd_pend;
        if (rd_pend) begin
            m0_readdata = read_pattern(rd_addr);
            reads_seen++;
        end
    end

endmodule

//--- tb/tb_mspe.sv
`timescale 1ns/100ps

module tb_mspe import mspe_pkg::*; ();

    localparam int ROWS   = 6;
    localparam int PERIOD = 40;
    localparam logic [2:0] K_CSR = 3'd0, K_WRITE = 3'd1, K_READ = 3'd2;
    localparam logic [2:0] K_PKT = 3'd3, K_UART = 3'd4;

    typedef struct packed {
        logic [2:0]                 kind;
        logic [CORES-1:0]           run;
        logic                       rand_ready;
        word_t [CORES-1:0][7:0]     prog;
    } row_t;

    logic clk, reset;
    logic [4:0] csr_address;
    word_t csr_writedata, csr_readdata, insn_din, uart_dout;
    logic csr_write, csr_read, insn_we, uart_we;
    logic [3:0] csr_byteenable;
    logic [CORE_SEL_W+INSN_DEPTH+1:0] insn_addr;
    beat_t snk_data, src_data, m0_readdata, m0_writedata;
    logic snk_valid, snk_sop, snk_eop, snk_ready, src_valid, src_sop, src_eop, src_ready;
    logic m0_waitrequest, m0_readdatavalid, m0_write, m0_read, m0_debugaccess;
    logic [2:0] m0_burstcount;
    logic [63:0] m0_address, m0_byteenable;

    row_t      table_rows [ROWS];
    bit [31:0] lcg = 32'd53472;
    logic      rand_mode = 1'b0;
    int        last_core = CORES - 1;  // Scheduler serves core 0 first

    mspe UUT (.*);

    mspe_checker u_chk (
        .clk, .reset, .src_data, .src_valid, .src_sop, .src_eop, .src_ready,
        .uart_dout, .uart_we, .m0_write, .m0_read, .m0_address, .m0_writedata,
        .m0_byteenable, .m0_burstcount, .m0_debugaccess,
        .m0_waitrequest, .m0_readdata, .m0_readdatavalid
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(ROWS * 2000 * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    function automatic word_t next_word();
        lcg = lcg * 32'd1103515245 + 32'd12345;
        return lcg;
    endfunction

    function automatic word_t insn(opcode_t op, logic [15:0] imm);
        return {op, 12'h000, imm};
    endfunction

    always @(posedge clk) begin
        #2;
        src_ready = rand_mode ? next_word() >> 20 : 1'b1;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic csr_wr(logic [4:0] addr, word_t data, logic [3:0] be);
        csr_address = addr;
        csr_writedata = data;
        csr_byteenable = be;
        csr_write = 1'b1;
        tick();
        csr_write = 1'b0;
    endtask

    task automatic csr_rd(logic [4:0] addr, output word_t data);
        csr_address = addr;
        csr_read = 1'b1;
        tick();
        csr_read = 1'b0;
        data = csr_readdata;
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    function automatic row_t packet_row(logic rnd);
        row_t r = '0;
        logic [15:0] k, m;
        r.kind = K_PKT;
        r.run = 4'b1111;
        r.rand_ready = rnd;
        for (int c = 0; c < CORES; c++) begin
            k = 16'h0100 * (c + 1) + (rnd ? 16'h0033 : 16'h0005);
            m = 16'hA5A0 + 16'(c) + (rnd ? 16'h0800 : 16'h0000);
            r.prog[c] = {insn(HALT, 0), insn(STOREE, 0), insn(ADDI, k), insn(LOADB, 0),
                         insn(STOREB, 0), insn(XORI, m), insn(ADDI, k), insn(LOADB, 0)};
        end
        return r;
    endfunction

    task automatic fill_table();
        table_rows[0] = '{kind: K_CSR, default: '0};
        table_rows[1] = '{kind: K_WRITE, default: '0};
        table_rows[2] = '{kind: K_READ, default: '0};
        table_rows[3] = packet_row(1'b0);
        table_rows[4] = packet_row(1'b1);
        table_rows[5] = '{kind: K_UART, run: 4'b0010, default: '0};
        table_rows[5].prog[1][2:0] = {insn(HALT, 0), insn(PUTC, 16'h42), insn(PUTC, 16'h41)};
        table_rows[5].prog[0][1:0] = {insn(HALT, 0), insn(PUTC, 16'h78)};  // Core held off
    endtask

    task automatic load_programs(row_t r);
        for (int c = 0; c < CORES; c++) begin
            for (int i = 0; i < 8; i++) begin
                insn_addr = {2'(c), 6'(i), 2'b00};
                insn_din = r.prog[c][i];
                insn_we = 1'b1;
                tick();
            end
        end
        insn_we = 1'b0;
    endtask

    task automatic csr_map_test();
        word_t v;
        csr_rd(CSR_VERSION_R, v);
        u_chk.check_val("csr_readdata", VERSION, v);
        csr_wr(CSR_RUN_W, 32'hA5A5_A5A0, 4'b1010);
        csr_rd(CSR_RUN_R, v);
        u_chk.check_val("csr_readdata", 32'hA500_A500, v);
        csr_rd(5'd5, v);
        u_chk.check_val("csr_readdata", 32'hDEAD_BEEF, v);
        csr_wr(CSR_RUN_W, 0, 4'b1111);
    endtask

    task automatic mem_master_test(logic rd);
        logic [63:0] addr;
        beat_t data;
        int n0;
        word_t v;
        addr = {next_word(), next_word()};
        csr_wr(CSR_ADDR_HI, addr[63:32], 4'hF);
        csr_wr(CSR_ADDR_LO, addr[31:0], 4'hF);
        for (int j = 0; j < LANES; j++) begin
            data[15-j] = next_word();
            csr_wr(CSR_DATA_BASE + 5'(j), data[15-j], 4'hF);
        end
        n0 = rd ? u_chk.reads_seen : u_chk.writes_seen;
        csr_wr(CSR_KICK, rd ? 2 : 1, 4'hF);
        while ((rd ? u_chk.reads_seen : u_chk.writes_seen) == n0) tick();
        repeat (10) tick();
        csr_wr(CSR_KICK, 0, 4'hF);
        u_chk.check_val(rd ? "m0_read count" : "m0_write count", n0 + 1,
                        rd ? u_chk.reads_seen : u_chk.writes_seen);
        if (!rd) begin
            u_chk.check_val("m0_address", addr, u_chk.last_waddr);
            u_chk.check_val("m0_writedata", data, u_chk.last_wdata);
            u_chk.check_val("m0_byteenable", {64{1'b1}}, u_chk.last_be);
        end else begin
            data = u_chk.read_pattern(addr);
            for (int j = 0; j < LANES; j++) begin
                csr_rd(CSR_DATA_BASE + 5'(j), v);
                u_chk.check_val("csr_readdata", data[15-j], v);
            end
        end
    endtask

    task automatic packet_test(row_t r);
        beat_t beats [2];
        beat_t x;
        word_t k, m, v;
        int c;
        csr_wr(CSR_RUN_W, 0, 4'hF);
        load_programs(r);
        for (int b = 0; b < 2; b++) begin
            for (int l = 0; l < LANES; l++) beats[b][l] = next_word();
        end
        for (int n = 1; n <= CORES; n++) begin
            c = (last_core + n) % CORES;
            if (r.run[c]) begin
                k = {16'h0, r.prog[c][1][15:0]};
                m = {16'h0, r.prog[c][2][15:0]};
                for (int b = 0; b < 2; b++) begin
                    for (int l = 0; l < LANES; l++) begin
                        x[l] = (b == 0) ? ((beats[b][l] + k) ^ m) : (beats[b][l] + k);
                    end
                    u_chk.expect_beat(x, b == 0, b == 1);
                end
            end
        end
        for (int n = 1; n <= CORES; n++) begin
            if (r.run[(last_core + n) % CORES]) c = (last_core + n) % CORES;
        end
        last_core = c;
        rand_mode = r.rand_ready;
        csr_wr(CSR_RUN_W, {28'h0, r.run}, 4'hF);
        for (int b = 0; b < 2; b++) begin
            snk_data = beats[b];
            snk_valid = 1'b1;
            while (!snk_ready) tick();
            tick();
        end
        snk_valid = 1'b0;
        while (u_chk.pending() != 0) tick();
        rand_mode = 1'b0;
        repeat (4) tick();
        csr_rd(CSR_STATUS_R, v);
        u_chk.check_val("csr_readdata", {28'h0, r.run}, v);
    endtask

    task automatic uart_test(row_t r);
        word_t v;
        csr_wr(CSR_RUN_W, 0, 4'hF);
        load_programs(r);
        u_chk.expect_char(32'h41);
        u_chk.expect_char(32'h42);
        csr_wr(CSR_RUN_W, {28'h0, r.run}, 4'hF);
        v = 0;
        while (v[3:0] != r.run) csr_rd(CSR_STATUS_R, v);
        repeat (4) tick();
    endtask

    initial begin
        int e0;
        reset = 1'b1;
        {csr_address, csr_writedata, csr_write, csr_read, csr_byteenable} = '0;
        {insn_addr, insn_din, insn_we} = '0;
        {snk_data, snk_valid, snk_sop, snk_eop} = '0;
        src_ready = 1'b1;
        fill_table();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int t = 0; t < ROWS; t++) begin
            e0 = u_chk.errors;
            case (table_rows[t].kind)
                K_CSR:   csr_map_test();
                K_WRITE: mem_master_test(1'b0);
                K_READ:  mem_master_test(1'b1);
                K_PKT:   packet_test(table_rows[t]);
                default: uart_test(table_rows[t]);
            endcase
            u_chk.check_drained();
            $display("test %0d: %s", t + 1, (u_chk.errors == e0) ? "ok" : "errors");
        end
        $display("tests %0d, checks %0d, errors %0d", ROWS, u_chk.checks, u_chk.errors);
        if (u_chk.errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
design/mspe_pkg.sv
design/stream_fifo.sv
design/mspe_csr.sv
design/pe_core.sv
design/src_scheduler.sv
design/mspe.sv
tb/mspe_checker.sv
tb/tb_mspe.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mspe \
		-f project.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/Vtb_mspe); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
